/* cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,

    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  mem_cmd_pkg::mem_cmd_t in_i,

    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output mem_cmd_pkg::mem_cmd_t out_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    mem_cmd_pkg::mem_cmd_t buf_q [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty = (count_q == '0);

    assign in_ready_o  = ~full;
    assign out_valid_o = ~empty;

    assign push = in_valid_i & ~full;
    assign pop  = out_valid_o & out_ready_i;

    assign out_o = buf_q[rd_ptr_q];  // head entry

    // storage, no reset needed on payload
    always_ff @(posedge wb_clk_i) begin
        if (push) begin
            buf_q[wr_ptr_q] <= in_i;
        end
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                // wrap explicitly, depth need not be a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // none, or push and pop together
            endcase
        end
    end

endmodule

/* mem_cmd_pkg.sv */
package mem_cmd_pkg;

    // stream-side opcode, one bit
    typedef enum logic {
        MEM_RD = 1'b0,
        MEM_WR = 1'b1
    } mem_op_e;

    // command as seen on the input stream, 69 bits
    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;  // byte address, [1:0] unused
        logic [31:0] data;  // write data
        logic [3:0]  sel;   // bit n enables byte n
    } mem_cmd_t;

    // read response, one per read command
    typedef struct packed {
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

/* mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int MEM_WORDS  = 256,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,

    input  logic                  cmd_valid_i,
    output logic                  cmd_ready_o,
    input  mem_cmd_pkg::mem_cmd_t cmd_i,

    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output mem_cmd_pkg::mem_rsp_t rsp_o
);

    logic                  fifo_valid;
    logic                  fifo_ready;
    mem_cmd_pkg::mem_cmd_t fifo_cmd;
    wb_pkg::wb_req_t       wb_req;
    wb_pkg::wb_rsp_t       wb_rsp;

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (cmd_valid_i),
        .in_ready_o  (cmd_ready_o),
        .in_i        (cmd_i),
        .out_valid_o (fifo_valid),
        .out_ready_i (fifo_ready),
        .out_o       (fifo_cmd)
    );

    wb_host u_host (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (fifo_valid),
        .cmd_ready_o (fifo_ready),
        .cmd_i       (fifo_cmd),
        .wb_req_o    (wb_req),
        .wb_rsp_i    (wb_rsp),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    wb_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f tb.f --top-module tb_mem_subsys -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^TEST PASSED$" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* sram_bytelane.sv */
`timescale 1ns/1ps

module sram_bytelane #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         wb_clk_i,
    input  logic                         en_i,
    input  logic [3:0]                   we_i,     // one bit per byte lane
    input  logic [$clog2(MEM_WORDS)-1:0] addr_i,
    input  logic [31:0]                  wdata_i,
    output logic [31:0]                  rdata_o
);

    logic [31:0] mem [MEM_WORDS];

    // byte lanes written independently
    always_ff @(posedge wb_clk_i) begin
        if (en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (we_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge wb_clk_i) begin
        if (en_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

/* tb.f */
mem_cmd_pkg.sv
wb_pkg.sv
cmd_fifo.sv
sram_bytelane.sv
wb_sram.sv
wb_host.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int MEM_WORDS  = 256;
    localparam int FIFO_DEPTH = 4;
    localparam logic [31:0] SEED = 32'd98784;

    localparam int N_DIRECTED = 14;
    localparam int N_STALL    = 200;
    localparam int N_RANDOM   = 400;
    localparam int N_TOTAL    = N_DIRECTED + N_STALL + N_RANDOM;
    localparam int TIMEOUT_CYCLES = N_TOTAL * 20 + 500;

    // response ready policies
    localparam int READY_ALWAYS = 0;
    localparam int READY_STALLS = 1;
    localparam int READY_RANDOM = 2;

    logic                  wb_clk_i;
    logic                  rst_n_i;
    logic                  cmd_valid_i;
    logic                  cmd_ready_o;
    mem_cmd_pkg::mem_cmd_t cmd_i;
    logic                  rsp_valid_o;
    logic                  rsp_ready_i;
    mem_cmd_pkg::mem_rsp_t rsp_o;

    logic [31:0]           lfsr_q;
    logic [31:0]           model_mem [MEM_WORDS];
    logic                  written [MEM_WORDS];  // words safe to read back
    mem_cmd_pkg::mem_cmd_t send_q [$];
    logic [31:0]           exp_q [$];             // expected read data in order
    logic                  cmd_taken;
    logic                  saw_full;
    int                    value_errors;
    int                    other_errors;
    int                    reads_accepted;
    int                    rsp_count;

    mem_subsys_top #(
        .MEM_WORDS  (MEM_WORDS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_i       (cmd_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #5 wb_clk_i = ~wb_clk_i;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic void report_mismatch(input string name, input logic [31:0] want,
                                            input logic [31:0] got);
        value_errors++;
        $display("** Error at %0t: %s expected %h, got %h", $time, name, want, got);
    endfunction

    function automatic void report_failure(input string msg);
        other_errors++;
        $display("error at %0t: %s", $time, msg);
    endfunction

    // byte address to word index with wraparound
    function automatic int word_index(input logic [31:0] addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    function automatic mem_cmd_pkg::mem_cmd_t make_cmd(input mem_cmd_pkg::mem_op_e op,
                                                       input logic [31:0] addr,
                                                       input logic [31:0] data,
                                                       input logic [3:0] sel);
        mem_cmd_pkg::mem_cmd_t c;
        c.op   = op;
        c.addr = addr;
        c.data = data;
        c.sel  = sel;
        return c;
    endfunction

    function automatic void queue_cmd(input mem_cmd_pkg::mem_cmd_t c);
        if (c.op == mem_cmd_pkg::MEM_WR && c.sel == 4'hf) begin
            written[word_index(c.addr)] = 1'b1;
        end
        send_q.push_back(c);
    endfunction

    function automatic void add_random_cmds(input int n);
        mem_cmd_pkg::mem_cmd_t c;
        logic [31:0]           word;
        logic [31:0]           alias_v;
        logic [31:0]           low;
        for (int i = 0; i < n; i++) begin
            word    = rand_bits(4);   // 16 word window
            alias_v = rand_bits(3);   // copies above the array size
            low     = rand_bits(2);
            c.addr  = ((alias_v * MEM_WORDS) + word) * 4 + low;
            c.op    = (rand_bits(1) != 0) ? mem_cmd_pkg::MEM_WR : mem_cmd_pkg::MEM_RD;
            c.data  = rand_bits(32);
            c.sel   = 4'(rand_bits(4));
            if (!written[word_index(c.addr)]) begin
                c.op  = mem_cmd_pkg::MEM_WR;  // first touch fills the whole word
                c.sel = 4'hf;
            end
            queue_cmd(c);
        end
    endfunction

    // model update at the edge where the command is taken
    function automatic void accept_cmd(input mem_cmd_pkg::mem_cmd_t c);
        int idx;
        idx = word_index(c.addr);
        if (c.op == mem_cmd_pkg::MEM_WR) begin
            for (int b = 0; b < 4; b++) begin
                if (c.sel[b]) begin
                    model_mem[idx][8*b +: 8] = c.data[8*b +: 8];
                end
            end
        end else begin
            exp_q.push_back(model_mem[idx]);
            reads_accepted++;
        end
    endfunction

    function automatic void check_rsp(input logic [31:0] got);
        logic [31:0] want;
        rsp_count++;
        assert (exp_q.size() > 0)
            else report_failure("response arrived with no read outstanding");
        if (exp_q.size() > 0) begin
            want = exp_q.pop_front();
            assert (got === want) else report_mismatch("rsp_o.rdata", want, got);
        end
    endfunction

    // handshakes driven here complete on the next rising edge
    task automatic run_queue(input int rdy_mode);
        int stall_cnt;
        stall_cnt = 0;
        while (send_q.size() > 0 || cmd_valid_i || exp_q.size() > 0) begin
            @(negedge wb_clk_i);
            if (cmd_taken) begin
                cmd_valid_i = 1'b0;
            end
            if (!cmd_valid_i && send_q.size() > 0 && rand_bits(2) != 0) begin
                cmd_i       = send_q.pop_front();
                cmd_valid_i = 1'b1;
            end
            case (rdy_mode)
                READY_ALWAYS: rsp_ready_i = 1'b1;
                READY_STALLS: begin
                    if (stall_cnt > 0) begin
                        stall_cnt--;
                        rsp_ready_i = 1'b0;
                    end else if (rand_bits(4) == 0) begin
                        stall_cnt   = 8 + int'(rand_bits(4));  // long hold-off
                        rsp_ready_i = 1'b0;
                    end else begin
                        rsp_ready_i = 1'b1;
                    end
                end
                default: rsp_ready_i = (rand_bits(2) != 0);
            endcase
            // registered outputs hold until the next rising edge
            cmd_taken = cmd_valid_i && cmd_ready_o;
            if (cmd_taken) begin
                accept_cmd(cmd_i);
            end
            if (!cmd_ready_o && rsp_valid_o && !rsp_ready_i) begin
                saw_full = 1'b1;  // fifo filled behind a held response
            end
            if (rsp_valid_o && rsp_ready_i) begin
                check_rsp(rsp_o.rdata);
            end
        end
    endtask

    task automatic check_quiet(input int cycles);
        rsp_ready_i = 1'b1;
        repeat (cycles) begin
            @(negedge wb_clk_i);
            assert (rsp_valid_o === 1'b0) else report_failure("extra response after all reads");
        end
    endtask

    initial begin
        lfsr_q         = SEED;
        rst_n_i        = 1'b0;
        cmd_valid_i    = 1'b0;
        cmd_i          = '0;
        rsp_ready_i    = 1'b0;
        cmd_taken      = 1'b0;
        saw_full       = 1'b0;
        value_errors   = 0;
        other_errors   = 0;
        reads_accepted = 0;
        rsp_count      = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            written[i] = 1'b0;
        end

        repeat (10) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        rst_n_i = 1'b1;
        @(negedge wb_clk_i);
        assert (cmd_ready_o === 1'b1)
            else report_mismatch("cmd_ready_o", 32'd1, {31'd0, cmd_ready_o});
        assert (rsp_valid_o === 1'b0)
            else report_mismatch("rsp_valid_o", 32'd0, {31'd0, rsp_valid_o});

        // full word round trip
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_WR, 32'h40, 32'hdeadbeef, 4'hf));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_RD, 32'h40, 32'h0, 4'hf));

        // byte merges
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_WR, 32'h44, 32'h11223344, 4'hf));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_WR, 32'h44, 32'haabbccdd, 4'b0101));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_RD, 32'h44, 32'h0, 4'hf));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_WR, 32'h44, 32'h55667788, 4'b1010));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_RD, 32'h44, 32'h0, 4'hf));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_WR, 32'h44, 32'hffffffff, 4'b0000));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_RD, 32'h44, 32'h0, 4'hf));

        // aliases above the array and in bits 1:0
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_WR, 32'h80, 32'h0badf00d, 4'hf));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_RD, 32'h80 + MEM_WORDS * 4, 32'h0, 4'hf));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_RD, 32'h83, 32'h0, 4'hf));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_WR, 32'h81 + MEM_WORDS * 12, 32'h00007700, 4'b0010));
        queue_cmd(make_cmd(mem_cmd_pkg::MEM_RD, 32'h80, 32'h0, 4'hf));
        run_queue(READY_ALWAYS);

        // back-pressure from the response side
        saw_full = 1'b0;
        add_random_cmds(N_STALL);
        run_queue(READY_STALLS);
        assert (saw_full) else report_failure("cmd_ready_o never fell while responses were held");

        add_random_cmds(N_RANDOM);
        run_queue(READY_RANDOM);
        check_quiet(20);
        assert (rsp_count == reads_accepted)
            else report_mismatch("response count", reads_accepted, rsp_count);

        $display("summary: %0d value errors, %0d other errors, %0d reads, %0d responses",
                 value_errors, other_errors, reads_accepted, rsp_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge wb_clk_i);
        $display("watchdog expired after %0d cycles, traffic did not drain", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* wb_host.sv */
`timescale 1ns/1ps

module wb_host (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,

    // popped from the command fifo
    input  logic                  cmd_valid_i,
    output logic                  cmd_ready_o,
    input  mem_cmd_pkg::mem_cmd_t cmd_i,

    // wishbone master side
    output wb_pkg::wb_req_t       wb_req_o,
    input  wb_pkg::wb_rsp_t       wb_rsp_i,

    // read responses, in command order
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output mem_cmd_pkg::mem_rsp_t rsp_o
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUS  = 2'd1,
        RESP = 2'd2
    } host_state_e;

    host_state_e           state_q;
    host_state_e           state_d;
    wb_pkg::wb_req_t       req_q;
    mem_cmd_pkg::mem_rsp_t rsp_q;
    logic                  pop;
    logic                  bus_done;

    // new command only taken when idle
    assign cmd_ready_o = (state_q == IDLE);
    assign pop         = cmd_valid_i & cmd_ready_o;
    assign bus_done    = (state_q == BUS) & wb_rsp_i.ack;

    assign wb_req_o    = req_q;
    assign rsp_valid_o = (state_q == RESP);
    assign rsp_o       = rsp_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pop) begin
                    state_d = BUS;
                end
            end
            BUS: begin
                if (wb_rsp_i.ack) begin
                    state_d = req_q.we ? IDLE : RESP;  // writes give no response
                end
            end
            RESP: begin
                if (rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            req_q   <= '0;
        end else begin
            state_q <= state_d;
            if (pop) begin
                // start of cycle, stb high from next clock
                req_q.cyc <= 1'b1;
                req_q.stb <= 1'b1;
                req_q.we  <= (cmd_i.op == mem_cmd_pkg::MEM_WR);
                req_q.adr <= cmd_i.addr;
                req_q.dat <= cmd_i.data;
                req_q.sel <= cmd_i.sel;
            end else if (bus_done) begin
                req_q.cyc <= 1'b0;  // drop right after ack
                req_q.stb <= 1'b0;
            end
        end
    end

    // capture read data with the ack
    always_ff @(posedge wb_clk_i) begin
        if (bus_done && !req_q.we) begin
            rsp_q.rdata <= wb_rsp_i.dat;
        end
    end

endmodule

/* wb_pkg.sv */
package wb_pkg;

    // host to slave, classic single-cycle wishbone
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    // slave to host
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;  // read data, valid with ack on reads
    } wb_rsp_t;

endpackage

/* wb_sram.sv */
`timescale 1ns/1ps

module wb_sram #(
    parameter int MEM_WORDS = 256
) (
    input  logic            wb_clk_i,
    input  logic            rst_n_i,
    input  wb_pkg::wb_req_t wb_req_i,
    output wb_pkg::wb_rsp_t wb_rsp_o
);

    localparam int ADR_W = $clog2(MEM_WORDS);

    logic             valid;
    logic             ram_wen;
    logic [3:0]       byte_we;
    logic [ADR_W-1:0] word_addr;
    logic [31:0]      ram_rdata;
    logic             ack_q;
    logic             ack_read_q;  // read delay flag

    assign valid = wb_req_i.cyc & wb_req_i.stb;

    // write only once per transfer, not again in the ack cycle
    assign ram_wen = valid & wb_req_i.we & ~ack_q;
    assign byte_we = wb_req_i.sel & {4{ram_wen}};

    // upper bits beyond the array are dropped, so accesses wrap
    assign word_addr = wb_req_i.adr[ADR_W+1:2];

    // write: ack one clock after stb
    // read: one extra clock for the ram output register
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            ack_read_q <= 1'b0;
        end else begin
            ack_q      <= wb_req_i.we ? (valid & ~ack_q) : ack_read_q;
            ack_read_q <= valid & ~wb_req_i.we & ~ack_q & ~ack_read_q;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = ram_rdata;

    sram_bytelane #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .wb_clk_i (wb_clk_i),
        .en_i     (valid),
        .we_i     (byte_we),
        .addr_i   (word_addr),
        .wdata_i  (wb_req_i.dat),
        .rdata_o  (ram_rdata)
    );

endmodule
